//--- sim/core_stimulus.txt
// 32-bit hex words. @00 program, @40 halt address, fetches, memory ops, stores, data words
// @48 initial data as (byte address, word), @50 expected stores as (address, data, strobe)
@00
24010100 2402FFFB 34038001 3C041234 // addiu r1, addiu r2 -5, ori r3, lui r4
00832821 00623023 0043382A 0043402B // addu, subu, slt, sltu
00A64824 00A65025 00A65826 00A66027 // and, or, xor, nor
284DFFFC 2C6EFFFF 304FF0F0 385000FF // slti, sltiu, andi, xori
AC250010 AC260014 AC270018 AC28001C // sw arithmetic results
AC290020 AC2A0024 AC2B0028 AC2C002C
AC2D0030 AC2E0034 AC2F0038 AC30003C
A0250050 A0250051 A0250052 A0250053 // sb at every byte lane
A4250054 A4250056 80310002 90320003 // sh both halves, lb, lbu
84330002 94340000 8C350000 80360001 // lh, lhu, lw, lb
AC310060 AC320064 AC330068 AC34006C // sw loaded values
AC350070 AC360074 10ED0001 AC250080 // beq taken over a sw
14ED0001 AC270084 14E80001 AC250088 // bne not taken, bne taken over a sw
08000036 AC25008C 00000000 7C000000 // j over a sw, nop, unsupported opcode
AC350090 08000039                   // last sw, halt jump to itself
@40
000000E4 00000037 00000020 0000001A 00000001
@48
00000100 85F27E03
@50
00000110 12348001 0000000F  00000114 00008006 0000000F // addu, subu
00000118 00000001 0000000F  0000011C 00000000 0000000F // slt, sltu
00000120 00008000 0000000F  00000124 12348007 0000000F // and, or
00000128 12340007 0000000F  0000012C EDCB7FF8 0000000F // xor, nor
00000130 00000001 0000000F  00000134 00000001 0000000F // slti, sltiu
00000138 0000F0F0 0000000F  0000013C FFFFFF04 0000000F // andi, xori
00000150 01010101 00000001  00000150 01010101 00000002 // sb lanes 0 and 1
00000150 01010101 00000004  00000150 01010101 00000008 // sb lanes 2 and 3
00000154 80018001 00000003  00000154 80018001 0000000C // sh low and high
00000160 FFFFFFF2 0000000F  00000164 00000085 0000000F // lb, lbu
00000168 FFFF85F2 0000000F  0000016C 00007E03 0000000F // lh, lhu
00000170 85F27E03 0000000F  00000174 0000007E 0000000F // lw, lb
00000184 00000001 0000000F  00000190 85F27E03 0000000F // after bne, after j

//--- list.f
src/cpu_pkg.sv
src/reg_file.sv
src/alu.sv
src/instr_decoder.sv
src/cpu_control.sv
src/mem_lane.sv
src/perf_counters.sv
src/mips_core.sv
sim/tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - files:
      - src/cpu_pkg.sv
      - src/reg_file.sv
      - src/alu.sv
      - src/instr_decoder.sv
      - src/cpu_control.sv
      - src/mem_lane.sv
      - src/perf_counters.sv
      - src/mips_core.sv
  - target: simulation
    files:
      - sim/tb_mips_core.sv

//--- sim/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core
    import cpu_pkg::*;
();

    localparam int          max_stall  = 3;
    localparam int          hdr_base   = 'h40;
    localparam int          data_base  = 'h48;
    localparam int          store_base = 'h50;
    localparam int          imem_words = 64;
    localparam int          dmem_words = 256;
    localparam int unsigned stall_seed = 32'h91dd9263;

    logic              clk;
    logic              rst;
    logic [xlen-1:0]   pc;
    logic              inst_req_valid;
    logic              inst_req_ready;
    logic [xlen-1:0]   instruction;
    logic              inst_valid;
    logic              inst_ready;
    logic [xlen-1:0]   mem_addr;
    logic              mem_write;
    logic [xlen-1:0]   write_data;
    logic [strb_w-1:0] write_strb;
    logic              mem_read;
    logic              mem_req_ready;
    logic [xlen-1:0]   read_data;
    logic              read_data_valid;
    logic              read_data_ready;
    logic [xlen-1:0]   perf_cycles;
    logic [xlen-1:0]   perf_instrs;
    logic [xlen-1:0]   perf_mem_ops;

    logic [31:0] stim [256];
    logic [31:0] imem [imem_words];
    logic [31:0] dmem [dmem_words];
    logic [31:0] halt_addr;
    logic [31:0] exp_instrs;
    logic [31:0] exp_mem_ops;
    logic [31:0] fetch_word;
    logic [31:0] load_word;
    logic        halted;
    int          n_stores;
    int          store_idx;
    int          errors;
    int          checks;
    int          cycle_count;
    int          cycle_limit;
    int          fetch_wait;
    int          instr_wait;
    int          dreq_wait;
    int          rdata_wait;

    mips_core mips_core_i (.*);

    always #20 clk = ~clk;

    function automatic int draw_stall();
        return int'($urandom % (max_stall + 1));
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Compare against the next expected store, then update the data memory
    task automatic check_store();
        logic known;
        int   i;
        known = 1'b0;
        for (i = 0; i < n_stores; i++) begin
            if (stim[store_base + 3*i] == mem_addr) begin
                known = 1'b1;
            end
        end
        if (!known || store_idx >= n_stores) begin
            errors++;
            $display("unexpected store of %h to address %h", write_data, mem_addr);
        end else begin
            check_value($sformatf("store %0d address", store_idx),
                        stim[store_base + 3*store_idx], mem_addr);
            check_value($sformatf("store %0d data", store_idx),
                        stim[store_base + 3*store_idx + 1], write_data);
            check_value($sformatf("store %0d strobe", store_idx),
                        stim[store_base + 3*store_idx + 2], {28'h0, write_strb});
            store_idx++;
        end
        for (i = 0; i < strb_w; i++) begin
            if (write_strb[i]) begin
                dmem[mem_addr[9:2]][8*i +: 8] = write_data[8*i +: 8];
            end
        end
    endtask

    task automatic grant_fetch();
        if (inst_req_valid && !halted) begin
            if (fetch_wait > 0) begin
                inst_req_ready <= 1'b0;
                fetch_wait--;
            end else begin
                inst_req_ready <= 1'b1;
                if (pc >= 4*imem_words) begin
                    errors++;
                    $display("fetch from %h lies outside the program memory", pc);
                end
                fetch_word = imem[pc[7:2]];
                // Core stays in fetch once the jump to itself is taken
                halted = (pc == halt_addr);
                fetch_wait = draw_stall();
            end
        end else begin
            inst_req_ready <= 1'b0;
        end
    endtask

    task automatic return_instruction();
        if (inst_ready) begin
            if (instr_wait > 0) begin
                inst_valid <= 1'b0;
                instr_wait--;
            end else begin
                inst_valid  <= 1'b1;
                instruction <= fetch_word;
                instr_wait = draw_stall();
            end
        end else begin
            inst_valid <= 1'b0;
        end
    endtask

    task automatic accept_data_request();
        if (mem_write && mem_read) begin
            errors++;
            $display("write and read requested in the same cycle at %h", mem_addr);
        end
        if (mem_write || mem_read) begin
            if (dreq_wait > 0) begin
                mem_req_ready <= 1'b0;
                dreq_wait--;
            end else begin
                mem_req_ready <= 1'b1;
                if (mem_addr >= 4*dmem_words) begin
                    errors++;
                    $display("data access to %h lies outside the data memory", mem_addr);
                end else if (mem_write) begin
                    check_store();
                end else begin
                    load_word = dmem[mem_addr[9:2]];
                end
                dreq_wait = draw_stall();
            end
        end else begin
            mem_req_ready <= 1'b0;
        end
    endtask

    task automatic return_read_data();
        if (read_data_ready) begin
            if (rdata_wait > 0) begin
                read_data_valid <= 1'b0;
                rdata_wait--;
            end else begin
                read_data_valid <= 1'b1;
                read_data       <= load_word;
                rdata_wait = draw_stall();
            end
        end else begin
            read_data_valid <= 1'b0;
        end
    endtask

    // Memory models decide on the falling edge, the core samples on the rising edge
    always @(negedge clk) begin
        if (rst) begin
            inst_req_ready  <= 1'b0;
            inst_valid      <= 1'b0;
            mem_req_ready   <= 1'b0;
            read_data_valid <= 1'b0;
        end else begin
            grant_fetch();
            return_instruction();
            accept_data_request();
            return_read_data();
        end
    end

    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not reach the halt address within %0d cycles",
                     cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int          i;
        int unsigned first_draw;
        logic [31:0] addr;
        logic [31:0] cycles_first;
        logic [31:0] cycles_second;
        clk             = 1'b0;
        rst             = 1'b1;
        inst_req_ready  = 1'b0;
        instruction     = '0;
        inst_valid      = 1'b0;
        mem_req_ready   = 1'b0;
        read_data       = '0;
        read_data_valid = 1'b0;
        halted          = 1'b0;
        fetch_word      = '0;
        load_word       = '0;
        store_idx       = 0;
        errors          = 0;
        checks          = 0;
        cycle_count     = 0;
        first_draw = $urandom(stall_seed);
        $readmemh("sim/core_stimulus.txt", stim);
        halt_addr   = stim[hdr_base];
        exp_instrs  = stim[hdr_base + 1];
        exp_mem_ops = stim[hdr_base + 2];
        n_stores    = stim[hdr_base + 3];
        for (i = 0; i < imem_words; i++) begin
            imem[i] = (i <= halt_addr[7:2]) ? stim[i] : '0;
        end
        // Background pattern from the full byte address
        for (i = 0; i < dmem_words; i++) begin
            addr    = 4*i;
            dmem[i] = {~addr[15:0], addr[15:0]};
        end
        for (i = 0; i < stim[hdr_base + 4]; i++) begin
            dmem[stim[data_base + 2*i][9:2]] = stim[data_base + 2*i + 1];
        end
        // Every fetch and every data access may stall up to max_stall twice
        cycle_limit = 40 * (halt_addr / 4 + 1) + max_stall * 2 * (exp_instrs + exp_mem_ops);
        fetch_wait  = draw_stall();
        instr_wait  = draw_stall();
        dreq_wait   = draw_stall();
        rdata_wait  = draw_stall();

        repeat (3) @(negedge clk);
        rst <= 1'b0;
        wait (halted);
        repeat (max_stall + 12) @(negedge clk);

        check_value("halt pc", halt_addr, pc);
        check_value("perf_instrs", exp_instrs, perf_instrs);
        check_value("perf_mem_ops", exp_mem_ops, perf_mem_ops);
        cycles_first = perf_cycles;
        repeat (2) @(negedge clk);
        cycles_second = perf_cycles;
        if (cycles_first == 0 || cycles_second <= cycles_first) begin
            errors++;
            $display("perf_cycles did not advance, read %0d and then %0d",
                     cycles_first, cycles_second);
        end
        if (store_idx != n_stores) begin
            errors++;
            $display("only %0d of %0d expected stores appeared", store_idx, n_stores);
        end

        $display("checks %0d, stores %0d, errors %0d", checks, store_idx, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core
    import cpu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    output logic      [xlen-1:0]   pc,
    output logic                   inst_req_valid,
    input  wire logic              inst_req_ready,
    input  wire logic [xlen-1:0]   instruction,
    input  wire logic              inst_valid,
    output logic                   inst_ready,
    output logic      [xlen-1:0]   mem_addr,
    output logic                   mem_write,
    output logic      [xlen-1:0]   write_data,
    output logic      [strb_w-1:0] write_strb,
    output logic                   mem_read,
    input  wire logic              mem_req_ready,
    input  wire logic [xlen-1:0]   read_data,
    input  wire logic              read_data_valid,
    output logic                   read_data_ready,
    output logic      [xlen-1:0]   perf_cycles,
    output logic      [xlen-1:0]   perf_instrs,
    output logic      [xlen-1:0]   perf_mem_ops
);

    logic [xlen-1:0]       instr_q;
    logic [xlen-1:0]       imm_ext;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       alu_b;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       load_value;
    logic [xlen-1:0]       wb_data;
    logic [reg_addr_w-1:0] rf_waddr;
    logic                  alu_zero;
    logic                  alu_src_imm;
    logic                  branch_ne;
    logic                  rf_write;
    logic                  rf_wen;
    logic                  load_unsigned;
    logic                  fetch_fire;
    logic                  mem_fire;
    instr_class_e          instr_class;
    alu_op_e               alu_op;
    mem_size_e             mem_size;
    wb_sel_e               wb_sel;

    cpu_control cpu_control_i (
        .clk            (clk),
        .rst            (rst),
        .inst_req_ready (inst_req_ready),
        .inst_valid     (inst_valid),
        .mem_req_ready  (mem_req_ready),
        .read_data_valid(read_data_valid),
        .instruction    (instruction),
        .instr_class    (instr_class),
        .branch_ne      (branch_ne),
        .alu_zero       (alu_zero),
        .imm_ext        (imm_ext),
        .pc             (pc),
        .instr_q        (instr_q),
        .inst_req_valid (inst_req_valid),
        .inst_ready     (inst_ready),
        .mem_write      (mem_write),
        .mem_read       (mem_read),
        .read_data_ready(read_data_ready),
        .rf_wen         (rf_wen),
        .fetch_fire     (fetch_fire),
        .mem_fire       (mem_fire)
    );

    instr_decoder instr_decoder_i (
        .instr        (instr_q),
        .instr_class  (instr_class),
        .alu_op       (alu_op),
        .alu_src_imm  (alu_src_imm),
        .branch_ne    (branch_ne),
        .rf_write     (rf_write),
        .load_unsigned(load_unsigned),
        .mem_size     (mem_size),
        .wb_sel       (wb_sel),
        .rf_waddr     (rf_waddr),
        .imm_ext      (imm_ext)
    );

    // Sources are always rs and rt of the held instruction
    reg_file reg_file_i (
        .clk   (clk),
        .rst   (rst),
        .raddr1(instr_q[25:21]),
        .raddr2(instr_q[20:16]),
        .waddr (rf_waddr),
        .wdata (wb_data),
        .wen   (rf_wen && rf_write),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    assign alu_b = alu_src_imm ? imm_ext : rdata2;

    alu alu_i (
        .a     (rdata1),
        .b     (alu_b),
        .op    (alu_op),
        .result(alu_result),
        .zero  (alu_zero)
    );

    mem_lane mem_lane_i (
        .clk            (clk),
        .addr_low       (alu_result[1:0]),
        .size           (mem_size),
        .load_unsigned  (load_unsigned),
        .store_src      (rdata2),
        .read_data      (read_data),
        .read_data_valid(read_data_valid),
        .read_data_ready(read_data_ready),
        .write_data     (write_data),
        .write_strb     (write_strb),
        .load_value     (load_value)
    );

    perf_counters perf_counters_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_fire  (fetch_fire),
        .mem_fire    (mem_fire),
        .perf_cycles (perf_cycles),
        .perf_instrs (perf_instrs),
        .perf_mem_ops(perf_mem_ops)
    );

    assign mem_addr = {alu_result[xlen-1:2], 2'b00};

    always_comb begin
        case (wb_sel)
            wb_upper: wb_data = {imm_ext[15:0], 16'h0000};
            wb_load:  wb_data = load_value;
            default:  wb_data = alu_result;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst)
        (mem_write || mem_read) && mem_size == size_half |-> !alu_result[0])
        else $error("mips_core: misaligned halfword access");

endmodule

`default_nettype wire

//--- src/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters
    import cpu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            fetch_fire,
    input  wire logic            mem_fire,
    output logic      [xlen-1:0] perf_cycles,
    output logic      [xlen-1:0] perf_instrs,
    output logic      [xlen-1:0] perf_mem_ops
);

    always_ff @(posedge clk) begin
        if (rst) begin
            perf_cycles  <= '0;
            perf_instrs  <= '0;
            perf_mem_ops <= '0;
        end else begin
            perf_cycles <= perf_cycles + 1'b1;
            // Accepted fetches, not retired instructions
            if (fetch_fire) begin
                perf_instrs <= perf_instrs + 1'b1;
            end
            if (mem_fire) begin
                perf_mem_ops <= perf_mem_ops + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/mem_lane.sv
`timescale 1ns/1ps
`default_nettype none

module mem_lane
    import cpu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic      [1:0]      addr_low,
    input  wire mem_size_e            size,
    input  wire logic                 load_unsigned,
    input  wire logic      [xlen-1:0] store_src,
    input  wire logic      [xlen-1:0] read_data,
    input  wire logic                 read_data_valid,
    input  wire logic                 read_data_ready,
    output logic           [xlen-1:0] write_data,
    output logic           [strb_w-1:0] write_strb,
    output logic           [xlen-1:0] load_value
);

    logic [xlen-1:0] read_q;
    logic [xlen-1:0] lane;

    // Replicate narrow store data so every lane carries it
    always_comb begin
        case (size)
            size_byte: begin
                write_data = {strb_w{store_src[7:0]}};
                write_strb = strb_w'(1) << addr_low;
            end
            size_half: begin
                write_data = {(strb_w/2){store_src[15:0]}};
                write_strb = strb_w'(2'b11) << {addr_low[1], 1'b0};
            end
            default: begin
                write_data = store_src;
                write_strb = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (read_data_valid && read_data_ready) begin
            read_q <= read_data;
        end
    end

    // Addressed byte or halfword lands at bit 0
    assign lane = read_q >> {addr_low, 3'b000};

    always_comb begin
        case (size)
            size_byte:
                load_value = {{(xlen-8){lane[7] & ~load_unsigned}}, lane[7:0]};
            size_half:
                load_value = {{(xlen-16){lane[15] & ~load_unsigned}}, lane[15:0]};
            default:
                load_value = read_q;
        endcase
    end

endmodule

`default_nettype wire

//--- src/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    inst_req_ready,
    input  wire logic                    inst_valid,
    input  wire logic                    mem_req_ready,
    input  wire logic                    read_data_valid,
    input  wire logic         [xlen-1:0] instruction,
    input  wire instr_class_e            instr_class,
    input  wire logic                    branch_ne,
    input  wire logic                    alu_zero,
    input  wire logic         [xlen-1:0] imm_ext,
    output logic              [xlen-1:0] pc,
    output logic              [xlen-1:0] instr_q,
    output logic                         inst_req_valid,
    output logic                         inst_ready,
    output logic                         mem_write,
    output logic                         mem_read,
    output logic                         read_data_ready,
    output logic                         rf_wen,
    output logic                         fetch_fire,
    output logic                         mem_fire
);

    state_e          state;
    state_e          state_next;
    logic [xlen-1:0] pc_plus;
    logic [xlen-1:0] pc_next;
    logic            branch_taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_rst;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_rst: state_next = st_if;
            st_if:  if (inst_req_ready) state_next = st_iw;
            st_iw:  if (inst_valid) state_next = st_id;
            st_id:  state_next = (instr_class == cls_nop) ? st_if : st_ex;
            st_ex: begin
                case (instr_class)
                    cls_alu:   state_next = st_wb;
                    cls_load:  state_next = st_ld;
                    cls_store: state_next = st_st;
                    default:   state_next = st_if;
                endcase
            end
            st_wb:  state_next = st_if;
            st_st:  if (mem_req_ready) state_next = st_if;
            st_ld:  if (mem_req_ready) state_next = st_rdw;
            st_rdw: if (read_data_valid) state_next = st_wb;
            default: state_next = st_rst;
        endcase
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            instr_q <= instruction;
        end
    end

    // ALU is subtracting rs and rt while in st_id
    assign branch_taken = (instr_class == cls_branch) && (alu_zero != branch_ne);
    assign pc_plus      = pc + pc_step;

    always_comb begin
        if (branch_taken) begin
            pc_next = pc_plus + {imm_ext[xlen-3:0], 2'b00};
        end else if (instr_class == cls_jump) begin
            pc_next = {pc_plus[xlen-1:xlen-4], instr_q[25:0], 2'b00};
        end else begin
            pc_next = pc_plus;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (state == st_id) begin
            pc <= pc_next;
        end
    end

    assign inst_req_valid  = (state == st_if);
    assign inst_ready      = (state == st_iw);
    assign mem_write       = (state == st_st);
    assign mem_read        = (state == st_ld);
    assign read_data_ready = (state == st_rdw);
    assign rf_wen          = (state == st_wb);
    assign fetch_fire      = inst_req_valid && inst_req_ready;
    assign mem_fire        = (mem_write || mem_read) && mem_req_ready;

    assert property (@(posedge clk) disable iff (rst) !(mem_write && mem_read))
        else $error("cpu_control: read and write requested together");

endmodule

`default_nettype wire

//--- src/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import cpu_pkg::*;
(
    input  wire logic         [xlen-1:0]       instr,
    output instr_class_e                       instr_class,
    output alu_op_e                            alu_op,
    output logic                               alu_src_imm,
    output logic                               branch_ne,
    output logic                               rf_write,
    output logic                               load_unsigned,
    output mem_size_e                          mem_size,
    output wb_sel_e                            wb_sel,
    output logic              [reg_addr_w-1:0] rf_waddr,
    output logic              [xlen-1:0]       imm_ext
);

    opcode_e               opcode;
    funct_e                funct;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [15:0]           imm;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm    = instr[15:0];

    always_comb begin
        instr_class = cls_nop;
        alu_op      = alu_add;
        alu_src_imm = 1'b0;
        branch_ne   = 1'b0;
        rf_write    = 1'b0;
        wb_sel      = wb_alu;
        rf_waddr    = rt;
        imm_ext     = {{(xlen-16){imm[15]}}, imm};
        case (opcode)
            op_special: begin
                instr_class = cls_alu;
                rf_write    = 1'b1;
                rf_waddr    = rd;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    // Includes the all-zero word
                    default: begin
                        instr_class = cls_nop;
                        rf_write    = 1'b0;
                    end
                endcase
            end
            op_addiu, op_slti, op_sltiu, op_lui: begin
                instr_class = cls_alu;
                alu_src_imm = 1'b1;
                rf_write    = 1'b1;
                if (opcode == op_slti) begin
                    alu_op = alu_slt;
                end else if (opcode == op_sltiu) begin
                    alu_op = alu_sltu;
                end else if (opcode == op_lui) begin
                    wb_sel = wb_upper;
                end
            end
            op_andi, op_ori, op_xori: begin
                instr_class = cls_alu;
                alu_src_imm = 1'b1;
                rf_write    = 1'b1;
                // Logical immediates are zero extended
                imm_ext     = {{(xlen-16){1'b0}}, imm};
                if (opcode == op_andi) begin
                    alu_op = alu_and;
                end else if (opcode == op_ori) begin
                    alu_op = alu_or;
                end else begin
                    alu_op = alu_xor;
                end
            end
            op_beq, op_bne: begin
                instr_class = cls_branch;
                alu_op      = alu_sub;
                branch_ne   = (opcode == op_bne);
            end
            op_j: instr_class = cls_jump;
            op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
                instr_class = cls_load;
                alu_src_imm = 1'b1;
                rf_write    = 1'b1;
                wb_sel      = wb_load;
            end
            op_sb, op_sh, op_sw: begin
                instr_class = cls_store;
                alu_src_imm = 1'b1;
            end
            default: instr_class = cls_nop;
        endcase
    end

    // Access width and extension, shared by loads and stores
    always_comb begin
        load_unsigned = (opcode == op_lbu) || (opcode == op_lhu);
        case (opcode)
            op_lb, op_lbu, op_sb: mem_size = size_byte;
            op_lh, op_lhu, op_sh: mem_size = size_half;
            default:              mem_size = size_word;
        endcase
    end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  wire logic    [xlen-1:0] a,
    input  wire logic    [xlen-1:0] b,
    input  wire alu_op_e            op,
    output logic         [xlen-1:0] result,
    output logic                    zero
);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_nor: result = ~(a | b);
            // Set-less-than results occupy bit 0 only
            alu_slt: begin
                result = xlen'($signed(a) < $signed(b));
            end
            alu_sltu: begin
                result = xlen'(a < b);
            end
            default: result = a + b;
        endcase
    end

    // Branches compare with a subtract and look at this flag
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [reg_addr_w-1:0] raddr1,
    input  wire logic [reg_addr_w-1:0] raddr2,
    input  wire logic [reg_addr_w-1:0] waddr,
    input  wire logic [xlen-1:0]       wdata,
    input  wire logic                  wen,
    output logic      [xlen-1:0]       rdata1,
    output logic      [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != ra_zero) begin
            regs[waddr] <= wdata;
        end
    end

    // Register 0 reads as zero regardless of array contents
    assign rdata1 = (raddr1 == ra_zero) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == ra_zero) ? '0 : regs[raddr2];

    assert property (@(posedge clk) disable iff (rst) wen |=> regs[ra_zero] == '0)
        else $error("reg_file: register 0 modified by a write");

endmodule

`default_nettype wire

//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 2 ** reg_addr_w;
    localparam int strb_w     = xlen / 8;

    localparam logic [reg_addr_w-1:0] ra_zero = '0;
    localparam logic [xlen-1:0]       pc_step = xlen'(4);

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lb      = 6'h20,
        op_lh      = 6'h21,
        op_lw      = 6'h23,
        op_lbu     = 6'h24,
        op_lhu     = 6'h25,
        op_sb      = 6'h28,
        op_sh      = 6'h29,
        op_sw      = 6'h2b
    } opcode_e;

    // Function field of op_special, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [2:0] {
        cls_nop, cls_alu, cls_load, cls_store, cls_branch, cls_jump
    } instr_class_e;

    typedef enum logic [1:0] {
        size_byte, size_half, size_word
    } mem_size_e;

    typedef enum logic [1:0] {
        wb_alu, wb_upper, wb_load
    } wb_sel_e;

    typedef enum logic [3:0] {
        st_rst, st_if, st_iw, st_id, st_ex, st_wb, st_st, st_ld, st_rdw
    } state_e;

endpackage

`default_nettype wire
